//--- src.f
+incdir+src
src/magic_seq_pkg.sv
src/seq_if.sv
src/axi_lite_decode.sv
src/seq_regs.sv
src/slot_sequencer.sv
src/magic_seq_top.sv
dv/magic_seq_properties.sv
dv/tb_magic_seq.sv

//--- run.sh
#!/bin/sh
# build and run the slot sequencer testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_magic_seq -Mdir obj_dir -o sim_magic_seq

# the simulation exits nonzero on a failed check, the log decides
./obj_dir/sim_magic_seq > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1

//--- dv/tb_magic_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "magic_seq_macros.svh"

module tb_magic_seq;
    import magic_seq_pkg::*;

    typedef enum logic [2:0] {K_WR, K_WR_BUSY, K_RD, K_START, K_WAIT_DONE} kind_e;

    typedef struct packed {
        kind_e                  kind;
        logic [`SEQ_ADDR_W-1:0] addr;
        logic [`SEQ_DATA_W-1:0] data;
        logic [`SEQ_DATA_W-1:0] exp_data;
        logic [1:0]             exp_resp;
        logic [3:0]             hold;       // cycles with bready / rready kept low
    } row_t;

    localparam logic [1:0] OKAY   = `SEQ_RESP_OKAY;
    localparam logic [1:0] SLVERR = `SEQ_RESP_SLVERR;

    logic                   clk;
    logic                   rst_n;
    logic [`SEQ_ADDR_W-1:0] s_axi_awaddr;
    logic                   s_axi_awvalid;
    logic [`SEQ_DATA_W-1:0] s_axi_wdata;
    logic                   s_axi_wvalid;
    logic                   s_axi_bready;
    logic [`SEQ_ADDR_W-1:0] s_axi_araddr;
    logic                   s_axi_arvalid;
    logic                   s_axi_rready;
    wire                    s_axi_awready;
    wire                    s_axi_wready;
    wire                    s_axi_bvalid;
    wire [1:0]              s_axi_bresp;
    wire                    s_axi_arready;
    wire                    s_axi_rvalid;
    wire [1:0]              s_axi_rresp;
    wire [`SEQ_DATA_W-1:0]  s_axi_rdata;
    bucket_msk_t            mgs_fin_exec = '0;
    bucket_msk_t            mgs_load_init;
    bucket_msk_t            mgs_store_init;
    bucket_msk_t            mgs_load_reset;
    bucket_msk_t            mgs_store_reset;

    // expected register contents
    bucket_msk_t mdl_ld [`SEQ_SLOT_CNT];
    bucket_msk_t mdl_st [`SEQ_SLOT_CNT];
    slot_idx_t   mdl_end;

    int          init_cnt = 0;      // counted by the streamer model
    int          rel_cnt = 0;
    int          init_base = 0;     // counts at the last start
    int          rel_base = 0;
    int unsigned fin_wait [`SEQ_MSK_W];
    bucket_msk_t last_ld;
    bucket_msk_t last_st;
    int          cycles = 0;
    int          cycle_limit = 2000;
    row_t        tbl [$];

    magic_seq_top uut (.*);

    bind slot_sequencer magic_seq_properties u_props (
        .clk(clk), .rst_n(rst_n), .state(state), .main_cnt(main_cnt_q),
        .end_cnt(slot.end_cnt),
        .load_init(mgs_load_init), .store_init(mgs_store_init),
        .load_reset(mgs_load_reset), .store_reset(mgs_store_reset)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit)
            abort_run($sformatf("timeout, no end of test after %0d cycles", cycles));
    end

    //////////////////////////////
    // compare tasks
    task automatic check_data(input string name, input logic [`SEQ_DATA_W-1:0] got,
                              input logic [`SEQ_DATA_W-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp));
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH time=%0t %s got=%b exp=%b", $time, name, got, exp));
    endtask

    task automatic check_mask(input string name, input bucket_msk_t got, input bucket_msk_t exp);
        if (got !== exp)
            abort_run($sformatf("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp));
    endtask

    //////////////////////////////
    // streamer model
    always @(negedge clk) begin
        bucket_msk_t fin;
        int          k;
        fin = '0;
        for (int b = 0; b < `SEQ_MSK_W; b++) begin
            if (fin_wait[b] == 1)
                fin[b] = 1'b1;
            if (fin_wait[b] != 0)
                fin_wait[b]--;
            if (mgs_store_init[b])
                fin_wait[b] = 1 + ($urandom % 6);   // finish 1 to 6 cycles later
        end
        mgs_fin_exec = fin;
        if (mgs_load_init != '0 || mgs_store_init != '0) begin
            k = init_cnt - init_base;
            if (k > int'(mdl_end))
                abort_run("init pulse seen after the last slot of the run");
            check_mask("mgs_load_init", mgs_load_init, mdl_ld[k]);
            check_mask("mgs_store_init", mgs_store_init, mdl_st[k]);
            last_ld = mgs_load_init;
            last_st = mgs_store_init;
            init_cnt++;
        end
        if (mgs_load_reset != '0 || mgs_store_reset != '0) begin
            check_mask("mgs_load_reset", mgs_load_reset, last_ld);  // same slot as its init
            check_mask("mgs_store_reset", mgs_store_reset, last_st);
            rel_cnt++;
        end
    end

    //////////////////////////////
    // axi-lite master, entered and left on a falling edge
    task automatic axi_write(input logic [`SEQ_ADDR_W-1:0] addr,
                             input logic [`SEQ_DATA_W-1:0] data, input int hold,
                             output logic [1:0] resp);
        logic hs;
        hs            = 1'b0;
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        while (!hs) begin
            #1 hs = s_axi_awready;      // ready is settled mid low phase
            if (s_axi_wready !== hs)
                abort_run("wready and awready did not rise together");
            @(negedge clk);
        end
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        while (!s_axi_bvalid)
            @(negedge clk);
        resp = s_axi_bresp;
        repeat (hold) begin
            @(negedge clk);
            if (!s_axi_bvalid)
                abort_run("bvalid dropped while bready was low");
            check_resp("s_axi_bresp", s_axi_bresp, resp);
        end
        s_axi_bready = 1'b1;
        @(negedge clk);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [`SEQ_ADDR_W-1:0] addr, input int hold,
                            output logic [`SEQ_DATA_W-1:0] data, output logic [1:0] resp);
        logic hs;
        hs            = 1'b0;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        while (!hs) begin
            #1 hs = s_axi_arready;
            @(negedge clk);
        end
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid)
            @(negedge clk);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        repeat (hold) begin
            @(negedge clk);
            if (!s_axi_rvalid)
                abort_run("rvalid dropped while rready was low");
            check_data("s_axi_rdata", s_axi_rdata, data);
            check_resp("s_axi_rresp", s_axi_rresp, resp);
        end
        s_axi_rready = 1'b1;
        @(negedge clk);
        s_axi_rready = 1'b0;
    endtask

    //////////////////////////////
    // stimulus table
    function automatic logic [`SEQ_ADDR_W-1:0] slot_addr(input int i, input int off);
        return 16'(`SEQ_ADDR_SLOT_BASE + i * 16 + off);
    endfunction

    function automatic bucket_msk_t ld_pattern(input int i);
        return 8'(8'hA5 ^ (i * 8'h13));
    endfunction

    function automatic bucket_msk_t st_pattern(input int i);
        return 8'((1 << i) | (1 << ((i + 3) % 8)));    // never zero
    endfunction

    function automatic void add_row(input kind_e kind, input logic [`SEQ_ADDR_W-1:0] addr,
                                    input logic [`SEQ_DATA_W-1:0] data,
                                    input logic [`SEQ_DATA_W-1:0] exp_data,
                                    input logic [1:0] exp_resp, input logic [3:0] hold);
        row_t r;
        r.kind     = kind;
        r.addr     = addr;
        r.data     = data;
        r.exp_data = exp_data;
        r.exp_resp = exp_resp;
        r.hold     = hold;
        tbl.push_back(r);
    endfunction

    function automatic void build_table();
        add_row(K_RD, `SEQ_ADDR_STATUS, 0, 0, OKAY, 0);     // reset values
        add_row(K_RD, `SEQ_ADDR_MAIN_CNT, 0, 0, OKAY, 0);
        add_row(K_RD, `SEQ_ADDR_END_CNT, 0, 0, OKAY, 0);
        for (int i = 0; i < `SEQ_SLOT_CNT; i++) begin
            add_row(K_RD, slot_addr(i, 0), 0, 0, OKAY, 0);
            add_row(K_RD, slot_addr(i, 4), 0, 0, OKAY, 0);
        end
        for (int i = 0; i < `SEQ_SLOT_CNT; i++) begin
            add_row(K_WR, slot_addr(i, 0), 32'(ld_pattern(i)), 0, OKAY, 0);
            add_row(K_WR, slot_addr(i, 4), 32'(st_pattern(i)), 0, OKAY, 0);
        end
        add_row(K_WR, `SEQ_ADDR_END_CNT, 5, 0, OKAY, 0);
        for (int i = 0; i < `SEQ_SLOT_CNT; i++) begin
            add_row(K_RD, slot_addr(i, 0), 0, 32'(ld_pattern(i)), OKAY, 0);
            add_row(K_RD, slot_addr(i, 4), 0, 32'(st_pattern(i)), OKAY, 0);
        end
        add_row(K_RD, `SEQ_ADDR_END_CNT, 0, 5, OKAY, 0);
        add_row(K_WR, 16'h0040, 32'hFF, 0, SLVERR, 0);       // hole in bank0
        add_row(K_WR, `SEQ_ADDR_STATUS, 1, 0, SLVERR, 0);   // read only
        add_row(K_RD, 16'h0040, 0, 0, SLVERR, 0);
        add_row(K_RD, slot_addr(2, 8), 0, 0, SLVERR, 0);
        // run slots 0 to 5
        add_row(K_START, `SEQ_ADDR_CONTROL, 1, 0, OKAY, 0);
        add_row(K_WAIT_DONE, `SEQ_ADDR_STATUS, 0, 2, OKAY, 0);
        add_row(K_RD, `SEQ_ADDR_MAIN_CNT, 0, 6, OKAY, 0);
        // full table with traffic while busy
        add_row(K_WR, `SEQ_ADDR_END_CNT, 7, 0, OKAY, 0);
        add_row(K_START, `SEQ_ADDR_CONTROL, 1, 0, OKAY, 0);
        add_row(K_WR, `SEQ_ADDR_CONTROL, 1, 0, OKAY, 0);    // no restart
        add_row(K_WR_BUSY, slot_addr(3, 4), 32'hF0, 0, OKAY, 0);
        add_row(K_WAIT_DONE, `SEQ_ADDR_STATUS, 0, 2, OKAY, 0);
        add_row(K_RD, `SEQ_ADDR_MAIN_CNT, 0, 8, OKAY, 0);
        add_row(K_RD, slot_addr(3, 4), 0, 32'hF0, OKAY, 0);
        // slow response acceptance
        add_row(K_WR, `SEQ_ADDR_END_CNT, 2, 0, OKAY, 5);
        add_row(K_RD, `SEQ_ADDR_END_CNT, 0, 2, OKAY, 5);
        add_row(K_RD, 16'h0040, 0, 0, SLVERR, 4);
    endfunction

    function automatic void track_write(input logic [`SEQ_ADDR_W-1:0] addr,
                                        input logic [`SEQ_DATA_W-1:0] data);
        if (addr == `SEQ_ADDR_END_CNT) begin
            mdl_end = data[`SEQ_IDX_W-1:0];
        end else if (addr >= `SEQ_ADDR_SLOT_BASE &&
                     addr < `SEQ_ADDR_SLOT_BASE + 16 * `SEQ_SLOT_CNT) begin
            if (addr[3:0] == 4'h0)
                mdl_ld[addr[6:4]] = data[`SEQ_MSK_W-1:0];
            else if (addr[3:0] == 4'h4)
                mdl_st[addr[6:4]] = data[`SEQ_MSK_W-1:0];
        end
    endfunction

    task automatic apply_row(input row_t r);
        logic [`SEQ_DATA_W-1:0] rd;
        logic [1:0]             rs;
        case (r.kind)
            K_WR, K_WR_BUSY, K_START: begin
                if (r.kind == K_START) begin
                    init_base = init_cnt;
                    rel_base  = rel_cnt;
                end
                if (r.kind == K_WR_BUSY && rel_cnt - rel_base > int'(mdl_end))
                    abort_run("sequencer was already idle when the slot write was issued");
                axi_write(r.addr, r.data, int'(r.hold), rs);
                check_resp("s_axi_bresp", rs, r.exp_resp);
                if (r.kind == K_WR_BUSY && rel_cnt - rel_base != int'(mdl_end) + 1)
                    abort_run("write response came back before the last slot released");
                if (rs == OKAY)
                    track_write(r.addr, r.data);
            end
            K_RD: begin
                axi_read(r.addr, int'(r.hold), rd, rs);
                check_data($sformatf("s_axi_rdata @%h", r.addr), rd, r.exp_data);
                check_resp("s_axi_rresp", rs, r.exp_resp);
            end
            K_WAIT_DONE: begin
                do begin
                    axi_read(r.addr, 0, rd, rs);
                end while (rd[0]);      // busy
                check_data("status", rd, r.exp_data);
                check_resp("s_axi_rresp", rs, r.exp_resp);
                if (init_cnt - init_base != int'(mdl_end) + 1)
                    abort_run($sformatf("run gave %0d init pulses instead of %0d",
                                        init_cnt - init_base, int'(mdl_end) + 1));
                if (rel_cnt - rel_base != init_cnt - init_base)
                    abort_run("number of releases differs from number of inits");
            end
            default: abort_run("unknown row kind in the stimulus table");
        endcase
    endtask

    initial begin
        void'($urandom(6));
        rst_n         = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        mdl_end       = '0;
        for (int i = 0; i < `SEQ_SLOT_CNT; i++) begin
            mdl_ld[i] = '0;
            mdl_st[i] = '0;
        end
        build_table();
        cycle_limit = 200 * tbl.size() + 2000;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_mask("mgs_load_init", mgs_load_init, '0);
        check_mask("mgs_store_init", mgs_store_init, '0);
        check_mask("mgs_load_reset", mgs_load_reset, '0);
        check_mask("mgs_store_reset", mgs_store_reset, '0);

        foreach (tbl[n])
            apply_row(tbl[n]);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/magic_seq_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "magic_seq_macros.svh"

module magic_seq_properties (
    input wire                             clk,
    input wire                             rst_n,
    input wire magic_seq_pkg::seq_state_e  state,
    input wire [`SEQ_IDX_W:0]              main_cnt,
    input wire magic_seq_pkg::slot_idx_t   end_cnt,
    input wire magic_seq_pkg::bucket_msk_t load_init,
    input wire magic_seq_pkg::bucket_msk_t store_init,
    input wire magic_seq_pkg::bucket_msk_t load_reset,
    input wire magic_seq_pkg::bucket_msk_t store_reset
);
    import magic_seq_pkg::*;

    logic init_on;
    logic release_on;

    assign init_on    = (load_init != '0) || (store_init != '0);
    assign release_on = (load_reset != '0) || (store_reset != '0);

    //////////////////////////////
    // streamer pulse shape
    a_init_single: assert property (@(posedge clk) disable iff (!rst_n) init_on |=> !init_on)
        else $error("init masks held longer than one cycle");

    a_release_single: assert property (@(posedge clk) disable iff (!rst_n)
        release_on |=> !release_on)
        else $error("reset masks held longer than one cycle");

    a_init_in_state: assert property (@(posedge clk) disable iff (!rst_n)
        (state != SEQ_INIT) |-> !init_on)
        else $error("init masks driven outside the init state");

    // end count is frozen while walking
    a_main_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
        (state != SEQ_IDLE) |-> (main_cnt <= end_cnt + 1'b1))
        else $error("completed count ran past the end count");

endmodule

`default_nettype wire

//--- src/magic_seq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "magic_seq_macros.svh"

module magic_seq_top (
    input  wire                             clk,
    input  wire                             rst_n,
    // axi-lite slave, write side
    input  wire [`SEQ_ADDR_W-1:0]           s_axi_awaddr,
    input  wire                             s_axi_awvalid,
    output wire                             s_axi_awready,
    input  wire [`SEQ_DATA_W-1:0]           s_axi_wdata,
    input  wire                             s_axi_wvalid,
    output wire                             s_axi_wready,
    output wire [1:0]                       s_axi_bresp,
    output wire                             s_axi_bvalid,
    input  wire                             s_axi_bready,
    // axi-lite slave, read side
    input  wire [`SEQ_ADDR_W-1:0]           s_axi_araddr,
    input  wire                             s_axi_arvalid,
    output wire                             s_axi_arready,
    output wire [`SEQ_DATA_W-1:0]           s_axi_rdata,
    output wire [1:0]                       s_axi_rresp,
    output wire                             s_axi_rvalid,
    input  wire                             s_axi_rready,
    // streamer buckets
    input  wire magic_seq_pkg::bucket_msk_t mgs_fin_exec,
    output wire magic_seq_pkg::bucket_msk_t mgs_load_init,
    output wire magic_seq_pkg::bucket_msk_t mgs_store_init,
    output wire magic_seq_pkg::bucket_msk_t mgs_load_reset,
    output wire magic_seq_pkg::bucket_msk_t mgs_store_reset
);

    reg_if  req_bus ();
    slot_if slot_bus ();

    axi_lite_decode u_decode (
        .clk(clk), .rst_n(rst_n),
        .s_axi_awaddr(s_axi_awaddr), .s_axi_awvalid(s_axi_awvalid),
        .s_axi_awready(s_axi_awready),
        .s_axi_wdata(s_axi_wdata), .s_axi_wvalid(s_axi_wvalid), .s_axi_wready(s_axi_wready),
        .s_axi_bresp(s_axi_bresp), .s_axi_bvalid(s_axi_bvalid), .s_axi_bready(s_axi_bready),
        .s_axi_araddr(s_axi_araddr), .s_axi_arvalid(s_axi_arvalid),
        .s_axi_arready(s_axi_arready),
        .s_axi_rdata(s_axi_rdata), .s_axi_rresp(s_axi_rresp),
        .s_axi_rvalid(s_axi_rvalid), .s_axi_rready(s_axi_rready),
        .req(req_bus.master)
    );

    seq_regs u_regs (.clk(clk), .rst_n(rst_n), .req(req_bus.target), .slot(slot_bus.bank));

    slot_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .slot(slot_bus.sequencer),
        .mgs_fin_exec(mgs_fin_exec),
        .mgs_load_init(mgs_load_init), .mgs_store_init(mgs_store_init),
        .mgs_load_reset(mgs_load_reset), .mgs_store_reset(mgs_store_reset)
    );

endmodule

`default_nettype wire

//--- src/slot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "magic_seq_macros.svh"

module slot_sequencer (
    input  wire                        clk,
    input  wire                        rst_n,
    slot_if.sequencer                  slot,
    input  wire magic_seq_pkg::bucket_msk_t mgs_fin_exec,     // one bit per store bucket
    output magic_seq_pkg::bucket_msk_t mgs_load_init,
    output magic_seq_pkg::bucket_msk_t mgs_store_init,
    output magic_seq_pkg::bucket_msk_t mgs_load_reset,
    output magic_seq_pkg::bucket_msk_t mgs_store_reset
);
    import magic_seq_pkg::*;

    seq_state_e          state;
    slot_idx_t           idx;
    bucket_msk_t         seen;          // finish bits gathered for this slot
    bucket_msk_t         seen_nxt;
    logic [`SEQ_IDX_W:0] main_cnt_q;
    logic                slot_done;
    logic                last_slot;

    assign seen_nxt  = seen | mgs_fin_exec;
    // an empty store mask is covered right away
    assign slot_done = (seen_nxt & slot.st_mask) == slot.st_mask;
    assign last_slot = (idx == slot.end_cnt);

    //////////////////////////////
    // slot walk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= SEQ_IDLE;
            idx        <= '0;
            seen       <= '0;
            main_cnt_q <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (slot.start) begin
                        state      <= SEQ_INIT;
                        idx        <= '0;
                        main_cnt_q <= '0;
                    end
                end
                SEQ_INIT: begin
                    seen  <= '0;
                    state <= SEQ_WAIT;
                end
                SEQ_WAIT: begin
                    seen <= seen_nxt;
                    if (slot_done)
                        state <= SEQ_RELEASE;
                end
                SEQ_RELEASE: begin
                    main_cnt_q <= main_cnt_q + 1'b1;
                    if (last_slot) begin
                        state <= SEQ_IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= SEQ_INIT;
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // streamer pulses, one cycle each
    assign mgs_load_init   = (state == SEQ_INIT)    ? slot.ld_mask : '0;
    assign mgs_store_init  = (state == SEQ_INIT)    ? slot.st_mask : '0;
    assign mgs_load_reset  = (state == SEQ_RELEASE) ? slot.ld_mask : '0;
    assign mgs_store_reset = (state == SEQ_RELEASE) ? slot.st_mask : '0;

    assign slot.index    = idx;
    assign slot.busy     = (state != SEQ_IDLE);
    assign slot.main_cnt = main_cnt_q;

endmodule

`default_nettype wire

//--- src/seq_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "magic_seq_macros.svh"

module seq_regs (
    input wire     clk,
    input wire     rst_n,
    reg_if.target  req,
    slot_if.bank   slot
);
    import magic_seq_pkg::*;

    bucket_msk_t            ld_mem [`SEQ_SLOT_CNT];
    bucket_msk_t            st_mem [`SEQ_SLOT_CNT];
    slot_idx_t              end_cnt_q;
    logic                   start_q;
    logic                   done_q;
    logic                   busy_q;     // for the falling edge of busy
    logic                   seq_active;
    logic                   cfg_wr;
    logic                   xfer;
    logic [`SEQ_DATA_W-1:0] rd_mux;

    //////////////////////////////
    // back-pressure
    // the table and end count are frozen from the start pulse to the last release
    assign seq_active = slot.busy | start_q;
    assign cfg_wr     = (req.op == OP_WR_END_CNT) || (req.op == OP_WR_LD_MASK) ||
                        (req.op == OP_WR_ST_MASK);
    assign req.ready  = ~(seq_active & cfg_wr);
    assign xfer       = req.valid & req.ready;

    assign slot.start   = start_q;
    assign slot.end_cnt = end_cnt_q;
    assign slot.ld_mask = ld_mem[slot.index];
    assign slot.st_mask = st_mem[slot.index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q   <= 1'b0;
            done_q    <= 1'b0;
            busy_q    <= 1'b0;
            end_cnt_q <= '0;
            for (int i = 0; i < `SEQ_SLOT_CNT; i++) begin
                ld_mem[i] <= '0;
                st_mem[i] <= '0;
            end
        end else begin
            // control writes while running are dropped
            start_q <= xfer && (req.op == OP_WR_CONTROL) && req.wdata[0] && !seq_active;
            busy_q  <= slot.busy;
            if (start_q)
                done_q <= 1'b0;
            else if (busy_q && !slot.busy)
                done_q <= 1'b1;     // last slot has released
            if (xfer) begin
                case (req.op)
                    OP_WR_END_CNT: end_cnt_q           <= req.wdata[`SEQ_IDX_W-1:0];
                    OP_WR_LD_MASK: ld_mem[req.index]   <= req.wdata[`SEQ_MSK_W-1:0];
                    OP_WR_ST_MASK: st_mem[req.index]   <= req.wdata[`SEQ_MSK_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////
    // readback
    always_comb begin
        rd_mux = '0;    // also the answer for OP_BAD
        case (req.op)
            OP_RD_STATUS:   rd_mux[1:0]              = {done_q, slot.busy};
            OP_RD_MAIN_CNT: rd_mux[`SEQ_IDX_W:0]     = slot.main_cnt;
            OP_RD_END_CNT:  rd_mux[`SEQ_IDX_W-1:0]   = end_cnt_q;
            OP_RD_LD_MASK:  rd_mux[`SEQ_MSK_W-1:0]   = ld_mem[req.index];
            OP_RD_ST_MASK:  rd_mux[`SEQ_MSK_W-1:0]   = st_mem[req.index];
            default: ;
        endcase
    end

    assign req.rdata = rd_mux;

endmodule

`default_nettype wire

//--- src/axi_lite_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "magic_seq_macros.svh"

module axi_lite_decode (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire [`SEQ_ADDR_W-1:0]  s_axi_awaddr,
    input  wire                    s_axi_awvalid,
    output logic                   s_axi_awready,
    input  wire [`SEQ_DATA_W-1:0]  s_axi_wdata,
    input  wire                    s_axi_wvalid,
    output logic                   s_axi_wready,
    output logic [1:0]             s_axi_bresp,
    output logic                   s_axi_bvalid,
    input  wire                    s_axi_bready,
    input  wire [`SEQ_ADDR_W-1:0]  s_axi_araddr,
    input  wire                    s_axi_arvalid,
    output logic                   s_axi_arready,
    output logic [`SEQ_DATA_W-1:0] s_axi_rdata,
    output logic [1:0]             s_axi_rresp,
    output logic                   s_axi_rvalid,
    input  wire                    s_axi_rready,
    reg_if.master                  req
);
    import magic_seq_pkg::*;

    localparam logic [`SEQ_ADDR_W-1:0] SLOT_BASE = `SEQ_ADDR_SLOT_BASE;
    localparam int SLOT_LSB = 4;                       // 16 bytes per slot
    localparam int SLOT_TOP = SLOT_LSB + `SEQ_IDX_W;   // first bit above the table

    logic                   aw_hs, ar_hs;
    logic                   wr_pend, rd_pend;   // held until the response is taken
    logic                   wr_req, rd_req;     // request sitting on reg_if
    logic                   wr_xfer, rd_xfer;
    reg_op_e                req_op;
    slot_idx_t              req_idx;
    logic [`SEQ_DATA_W-1:0] req_wdata;

    function automatic reg_op_e decode_op(input logic [`SEQ_ADDR_W-1:0] addr,
                                          input logic is_wr);
        reg_op_e op;
        op = OP_BAD;
        if (addr[`SEQ_ADDR_W-1:SLOT_TOP] == SLOT_BASE[`SEQ_ADDR_W-1:SLOT_TOP]) begin
            case (addr[SLOT_LSB-1:0])
                4'h0:    op = is_wr ? OP_WR_LD_MASK : OP_RD_LD_MASK;
                4'h4:    op = is_wr ? OP_WR_ST_MASK : OP_RD_ST_MASK;
                default: op = OP_BAD;
            endcase
        end else if (is_wr) begin
            case (addr)
                `SEQ_ADDR_CONTROL: op = OP_WR_CONTROL;
                `SEQ_ADDR_END_CNT: op = OP_WR_END_CNT;
                default:           op = OP_BAD;   // status and counters are read only
            endcase
        end else begin
            case (addr)
                `SEQ_ADDR_STATUS:   op = OP_RD_STATUS;
                `SEQ_ADDR_MAIN_CNT: op = OP_RD_MAIN_CNT;
                `SEQ_ADDR_END_CNT:  op = OP_RD_END_CNT;
                default:            op = OP_BAD;
            endcase
        end
        return op;
    endfunction

    //////////////////////////////
    // channel handshakes
    // write wins a same cycle tie, a read never passes an open write request
    assign aw_hs = s_axi_awvalid & s_axi_wvalid & ~wr_pend;
    assign ar_hs = s_axi_arvalid & ~rd_pend & ~wr_req & ~aw_hs;

    assign s_axi_awready = aw_hs;
    assign s_axi_wready  = aw_hs;
    assign s_axi_arready = ar_hs;

    assign wr_xfer = wr_req & req.ready;
    assign rd_xfer = rd_req & req.ready;

    assign req.valid = wr_req | rd_req;
    assign req.op    = req_op;
    assign req.index = req_idx;
    assign req.wdata = req_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_pend      <= 1'b0;
            rd_pend      <= 1'b0;
            wr_req       <= 1'b0;
            rd_req       <= 1'b0;
            s_axi_bvalid <= 1'b0;
            s_axi_rvalid <= 1'b0;
            s_axi_bresp  <= `SEQ_RESP_OKAY;
            s_axi_rresp  <= `SEQ_RESP_OKAY;
            req_op       <= OP_BAD;
            req_idx      <= '0;
        end else begin
            if (aw_hs) begin
                wr_pend <= 1'b1;
                req_op  <= decode_op(s_axi_awaddr, 1'b1);
                req_idx <= s_axi_awaddr[SLOT_LSB +: `SEQ_IDX_W];
            end else if (ar_hs) begin
                rd_pend <= 1'b1;
                req_op  <= decode_op(s_axi_araddr, 1'b0);
                req_idx <= s_axi_araddr[SLOT_LSB +: `SEQ_IDX_W];
            end
            wr_req <= aw_hs | (wr_req & ~req.ready);   // stalls while the bank is busy
            rd_req <= ar_hs | (rd_req & ~req.ready);

            if (wr_xfer) begin
                s_axi_bvalid <= 1'b1;
                s_axi_bresp  <= (req_op == OP_BAD) ? `SEQ_RESP_SLVERR : `SEQ_RESP_OKAY;
            end else if (s_axi_bvalid && s_axi_bready) begin
                s_axi_bvalid <= 1'b0;
                wr_pend      <= 1'b0;
            end

            if (rd_xfer) begin
                s_axi_rvalid <= 1'b1;
                s_axi_rresp  <= (req_op == OP_BAD) ? `SEQ_RESP_SLVERR : `SEQ_RESP_OKAY;
            end else if (s_axi_rvalid && s_axi_rready) begin
                s_axi_rvalid <= 1'b0;
                rd_pend      <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs)
            req_wdata <= s_axi_wdata;      // full word, no strobes
        if (rd_xfer)
            s_axi_rdata <= req.rdata;
    end

endmodule

`default_nettype wire

//--- src/seq_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "magic_seq_macros.svh"

// request path from the bus decoder into the register bank
interface reg_if;
    import magic_seq_pkg::*;

    logic                   valid;
    logic                   ready;
    reg_op_e                op;
    slot_idx_t              index;  // slot number for table accesses
    logic [`SEQ_DATA_W-1:0] wdata;
    logic [`SEQ_DATA_W-1:0] rdata;  // selected combinationally from op

    modport master (output valid, op, index, wdata, input ready, rdata);
    modport target (input valid, op, index, wdata, output ready, rdata);
endinterface

// bank to sequencer link
interface slot_if;
    import magic_seq_pkg::*;

    logic                 start;        // one cycle pulse
    slot_idx_t            end_cnt;
    bucket_msk_t          ld_mask;      // table entry at index
    bucket_msk_t          st_mask;
    slot_idx_t            index;
    logic                 busy;
    logic [`SEQ_IDX_W:0]  main_cnt;     // reaches slot count after a full table

    modport bank      (output start, end_cnt, ld_mask, st_mask, input index, busy, main_cnt);
    modport sequencer (input start, end_cnt, ld_mask, st_mask, output index, busy, main_cnt);
endinterface

`default_nettype wire

//--- src/magic_seq_pkg.sv
`default_nettype none

`include "magic_seq_macros.svh"

package magic_seq_pkg;

    // register operation decoded from one axi-lite access
    typedef enum logic [3:0] {
        OP_WR_CONTROL,
        OP_WR_END_CNT,
        OP_WR_LD_MASK,
        OP_WR_ST_MASK,
        OP_RD_STATUS,
        OP_RD_MAIN_CNT,
        OP_RD_END_CNT,
        OP_RD_LD_MASK,
        OP_RD_ST_MASK,
        OP_BAD              // unmapped, answered with slverr
    } reg_op_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_INIT,           // init pulse toward the buckets
        SEQ_WAIT,           // collecting store finish bits
        SEQ_RELEASE         // reset pulse, then next slot
    } seq_state_e;

    typedef logic [`SEQ_IDX_W-1:0] slot_idx_t;
    typedef logic [`SEQ_MSK_W-1:0] bucket_msk_t;

endpackage

`default_nettype wire

//--- src/magic_seq_macros.svh
`ifndef MAGIC_SEQ_MACROS_SVH
`define MAGIC_SEQ_MACROS_SVH

//////////////////////////////
// table geometry
`define SEQ_SLOT_CNT        8
`define SEQ_IDX_W           3       // log2 of slot count
`define SEQ_MSK_W           8       // one bit per streamer bucket

//////////////////////////////
// axi-lite bus widths
`define SEQ_ADDR_W          16
`define SEQ_DATA_W          32

//////////////////////////////
// bank0 register map
`define SEQ_ADDR_CONTROL    16'h0000
`define SEQ_ADDR_STATUS     16'h0004
`define SEQ_ADDR_MAIN_CNT   16'h0008
`define SEQ_ADDR_END_CNT    16'h000C
`define SEQ_ADDR_SLOT_BASE  16'h0100    // bank1, 16 bytes per slot

// bresp / rresp codes
`define SEQ_RESP_OKAY       2'b00
`define SEQ_RESP_SLVERR     2'b10

`endif
